//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_frontend
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_frontend.sv
`timescale 1ns/1ps

module tb_frontend;
   import fetch_pkg::*;

   // ====================
   // Setup
   // ====================
   localparam int ENTRIES   = 32;
   localparam int BUF_DEPTH = 4;
   localparam int IDX_W     = $clog2(ENTRIES);   // Counter index from pc bits above bit 1
   localparam int MEM_WORDS = 1024;              // 4 KB program space
   localparam int SEED      = 15520;
   localparam logic [XLEN-1:0] BR_PC = 32'h200;  // The one trained branch

   // out_ready policies
   localparam int RDY_HIGH = 0;
   localparam int RDY_LOW  = 1;
   localparam int RDY_RAND = 2;

   logic                             clk;
   logic                             rst_n;
   logic [XLEN-1:0]                  imem_addr;
   logic [FETCH_WIDTH-1:0][XLEN-1:0] imem_rdata;
   resolve_vec_t                     resolve;
   slot_t                            out_slot;
   logic                             out_valid;
   logic                             out_ready;

   logic [XLEN-1:0] mem    [MEM_WORDS];   // Program image
   opcode_e         kind_m [MEM_WORDS];   // Class of each word as placed
   logic [XLEN-1:0] off_m  [MEM_WORDS];   // Target offset of each placed word
   logic [1:0]      ctr_m  [ENTRIES];     // Reference copy of the counters
   slot_t           exp_q  [$];           // Expected stream in program order
   logic [XLEN-1:0] model_pc;             // Next pc in program order

   int    ready_mode;
   int    transfers;
   int    since_flush;                    // Cycles since the last flush
   logic  stalled_q;                      // Valid and not ready last cycle
   logic  flushed_q;                      // Flush at the last edge
   slot_t held_slot;
   logic  br_seen;
   logic  br_pred;
   int    checks;
   int    mismatches;
   int    timeouts;
   int    other_errs;

   frontend_top #(.ENTRIES(ENTRIES), .BUF_DEPTH(BUF_DEPTH)) dut (
      .clk          (clk),
      .rst_n_i      (rst_n),
      .imem_addr_o  (imem_addr),
      .imem_rdata_i (imem_rdata),
      .resolve_i    (resolve),
      .out_slot_o   (out_slot),
      .out_valid_o  (out_valid),
      .out_ready_i  (out_ready)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;             // 20 ns period
   end

   // Combinational memory returns word k at addr + 4k
   always_comb begin
      for (int k = 0; k < FETCH_WIDTH; k++) begin
         imem_rdata[k] = mem[imem_addr[11:2] + 10'(k)];
      end
   end

   // ====================
   // Program and model
   // ====================
   task automatic place_instr(input logic [XLEN-1:0] addr, input opcode_e op,
                              input logic [XLEN-1:0] off);
      logic [9:0] w;
      w         = addr[11:2];
      kind_m[w] = op;
      off_m[w]  = off;
      if (op == OP_JAL) begin
         // J-type jal with rd x1
         mem[w] = {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
      end else begin
         // B-type beq x1, x2
         mem[w] = {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], 7'b1100011};
      end
   endtask

   task automatic load_program();
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i]    = {25'(i), 7'b0010011};   // Unique OP-IMM filler per word
         kind_m[i] = OP_OTHER;
         off_m[i]  = '0;
      end
      place_instr(32'h014, OP_JAL, 32'h40);         // Slot 1 of group 0x10 jumps to 0x54
      place_instr(32'h070, OP_JAL, -32'sd48);       // Loop back to 0x40
      place_instr(BR_PC, OP_BRANCH, 32'h20);        // Taken path skips to 0x220
      place_instr(32'h230, OP_JAL, -32'sd48);       // Loop back to the branch
   endtask

   // Next slot in program order
   task automatic predict_next_slot();
      slot_t      s;
      logic [9:0] w;
      logic       taken;
      w     = model_pc[11:2];
      s.pc  = model_pc;
      s.instr = mem[w];
      taken = (kind_m[w] == OP_JAL) ||
              (kind_m[w] == OP_BRANCH && ctr_m[model_pc[IDX_W+1:2]] >= 2'd2);
      s.pred_taken = taken;
      model_pc = taken ? model_pc + off_m[w] : model_pc + 32'd4;
      exp_q.push_back(s);
   endtask

   // Counter training and flush with the oldest port first
   task automatic model_resolve(input resolve_vec_t rv);
      logic             older;
      logic             hit;
      logic [XLEN-1:0]  target;
      logic [IDX_W-1:0] i;
      older  = 1'b0;
      hit    = 1'b0;
      target = '0;
      for (int p = 0; p < RESOLVE_PORTS; p++) begin
         i = rv[p].pc[IDX_W+1:2];
         if (rv[p].valid && rv[p].is_branch && !older) begin
            if (rv[p].taken && ctr_m[i] != 2'd3) begin
               ctr_m[i] = ctr_m[i] + 2'd1;
            end else if (!rv[p].taken && ctr_m[i] != 2'd0) begin
               ctr_m[i] = ctr_m[i] - 2'd1;
            end
         end
         if (rv[p].valid && rv[p].mispredict && !older) begin
            hit    = 1'b1;
            target = rv[p].correct_pc;
         end
         older = older | (rv[p].valid & rv[p].mispredict);
      end
      flushed_q = hit;
      if (hit) begin
         exp_q.delete();                    // Wrong path is gone
         model_pc    = target;
         since_flush = 0;
      end
   endtask

   function automatic resolve_t make_resolve(input logic mis, input logic is_br,
                                             input logic taken, input logic [XLEN-1:0] pc,
                                             input logic [XLEN-1:0] cpc);
      resolve_t r;
      r.valid      = 1'b1;
      r.mispredict = mis;
      r.is_branch  = is_br;
      r.taken      = taken;
      r.pc         = pc;
      r.correct_pc = cpc;
      return r;
   endfunction

   // ====================
   // Drive and check
   // ====================
   task automatic step_cycle(input resolve_vec_t rv);
      slot_t exp_s;
      @(negedge clk);
      case (ready_mode)
         RDY_HIGH: out_ready = 1'b1;
         RDY_LOW:  out_ready = 1'b0;
         default:  out_ready = ($urandom % 3) != 0;   // Ready two times in three
      endcase
      resolve = rv;
      since_flush++;
      if (stalled_q && !flushed_q) begin
         checks++;
         assert (out_valid && out_slot == held_slot) else begin
            mismatches++;
            $display("Mismatch at %0t: stalled output moved to pc %h from pc %h",
                     $time, out_slot.pc, held_slot.pc);
         end
      end
      if (since_flush <= 2) begin           // Refill needs at least two cycles
         checks++;
         assert (!out_valid) else begin
            mismatches++;
            $display("Mismatch at %0t: out_valid_o high %0d cycle after flush",
                     $time, since_flush);
         end
      end
      if (out_valid && out_ready) begin     // Transfer at the coming edge
         while (exp_q.size() < 4) begin
            predict_next_slot();
         end
         exp_s = exp_q.pop_front();
         checks++;
         assert (out_slot == exp_s) else begin
            mismatches++;
            $display("Mismatch at %0t: got pc %h instr %h pred %0b, exp pc %h instr %h pred %0b",
                     $time, out_slot.pc, out_slot.instr, out_slot.pred_taken,
                     exp_s.pc, exp_s.instr, exp_s.pred_taken);
         end
         if (out_slot.pc == BR_PC) begin
            br_seen = 1'b1;
            br_pred = out_slot.pred_taken;
         end
         transfers++;
      end
      stalled_q = out_valid && !out_ready;
      held_slot = out_slot;
      model_resolve(rv);
   endtask

   task automatic idle_cycles(input int n);
      for (int c = 0; c < n; c++) begin
         step_cycle('0);
      end
   endtask

   task automatic run_transfers(input int n, input int limit);
      int start;
      int cyc;
      start = transfers;
      cyc   = 0;
      while ((transfers - start) < n && cyc < limit) begin
         step_cycle('0);
         cyc++;
      end
      if ((transfers - start) < n) begin
         timeouts++;
         $display("Timeout at %0t: only %0d of %0d instructions came out in %0d cycles",
                  $time, transfers - start, n, limit);
      end
   endtask

   task automatic check_branch(input logic exp_pred);
      if (!br_seen) begin
         other_errs++;
         $display("Error at %0t: the branch at %h never came out", $time, BR_PC);
      end else begin
         checks++;
         assert (br_pred == exp_pred) else begin
            mismatches++;
            $display("Mismatch at %0t: branch pred_taken %0b, expected %0b",
                     $time, br_pred, exp_pred);
         end
      end
   endtask

   // ====================
   // Test sequence
   // ====================
   initial begin
      resolve_vec_t rv;
      void'($urandom(SEED));
      for (int i = 0; i < ENTRIES; i++) begin
         ctr_m[i] = 2'd1;                   // Weakly not-taken
      end
      load_program();
      model_pc    = RESET_PC;
      ready_mode  = RDY_HIGH;
      transfers   = 0;
      since_flush = 100;
      stalled_q   = 1'b0;
      flushed_q   = 1'b0;
      held_slot   = '0;
      br_seen     = 1'b0;
      br_pred     = 1'b0;
      checks      = 0;
      mismatches  = 0;
      timeouts    = 0;
      other_errs  = 0;
      rst_n       = 1'b0;
      resolve     = '0;
      out_ready   = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      checks++;
      assert (!out_valid) else begin
         mismatches++;
         $display("Mismatch at %0t: out_valid_o set right after reset", $time);
      end

      // Straight line from reset into both JAL loops
      run_transfers(40, 400);

      // Port 1 mispredict alone
      rv[0] = make_resolve(1'b0, 1'b0, 1'b0, 32'h0, 32'h0);
      rv[1] = make_resolve(1'b1, 1'b0, 1'b0, 32'h0, BR_PC);
      step_cycle(rv);
      br_seen = 1'b0;
      run_transfers(20, 400);
      check_branch(1'b0);

      // Both ports mispredict and port 0 wins
      rv[0] = make_resolve(1'b1, 1'b0, 1'b0, 32'h0, 32'h40);
      step_cycle(rv);
      run_transfers(20, 400);

      // Two taken updates that each restart at the branch
      rv[0] = make_resolve(1'b1, 1'b1, 1'b1, BR_PC, BR_PC);
      rv[1] = '0;
      step_cycle(rv);
      run_transfers(4, 200);
      step_cycle(rv);
      br_seen = 1'b0;
      run_transfers(20, 400);
      check_branch(1'b1);

      // Two not-taken updates restore fall-through
      rv[0].taken = 1'b0;
      step_cycle(rv);
      run_transfers(4, 200);
      step_cycle(rv);
      br_seen = 1'b0;
      run_transfers(20, 400);
      check_branch(1'b0);

      // Port 1 update behind a port 0 mispredict is dropped
      rv[0] = make_resolve(1'b1, 1'b0, 1'b0, 32'h0, BR_PC);
      rv[1] = make_resolve(1'b0, 1'b1, 1'b1, BR_PC, 32'h0);
      step_cycle(rv);
      br_seen = 1'b0;
      run_transfers(20, 400);
      check_branch(1'b0);

      // Back-pressure from a restart at reset pc
      rv[0] = make_resolve(1'b1, 1'b0, 1'b0, 32'h0, RESET_PC);
      rv[1] = '0;
      ready_mode = RDY_LOW;
      step_cycle(rv);
      idle_cycles(25);                      // Buffer fills and fetch holds
      ready_mode = RDY_RAND;
      run_transfers(150, 2000);
      ready_mode = RDY_LOW;
      idle_cycles(30);
      ready_mode = RDY_RAND;
      run_transfers(60, 1000);
      ready_mode = RDY_HIGH;
      run_transfers(10, 200);

      $display("Checks %0d, mismatches %0d, timeouts %0d, other errors %0d",
               checks, mismatches, timeouts, other_errs);
      if (mismatches + timeouts + other_errs == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- project.f
src/fetch_pkg.sv
src/imm_decoder.sv
src/branch_predictor.sv
src/pc_gen.sv
src/fetch_unit.sv
src/inst_buffer.sv
src/group_serializer.sv
src/frontend_top.sv
bench/tb_frontend.sv

//--- src/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor #(
   parameter int ENTRIES = 32                        // Counter table size, power of two
)(
   input  logic                                                clk,
   input  logic                                                rst_n_i,
   input  logic [fetch_pkg::FETCH_WIDTH-1:0][fetch_pkg::XLEN-1:0] lookup_pc_i,
   output logic [fetch_pkg::FETCH_WIDTH-1:0]                   taken_o,
   input  logic [fetch_pkg::RESOLVE_PORTS-1:0]                 update_en_i,
   input  fetch_pkg::resolve_vec_t                             resolve_i
);
   import fetch_pkg::*;

   localparam int IDX_W = $clog2(ENTRIES);

   logic [1:0]       ctr_q   [ENTRIES];         // Bimodal 2-bit counters
   logic [IDX_W-1:0] upd_idx [RESOLVE_PORTS];   // Table index per resolve port

   // Saturating step, up on taken and down on not-taken
   function automatic logic [1:0] sat_next(input logic [1:0] ctr, input logic taken);
      if (taken) begin
         return (ctr == 2'd3) ? ctr : ctr + 2'd1;
      end
      return (ctr == 2'd0) ? ctr : ctr - 2'd1;
   endfunction

   // ====================
   // Lookup
   // ====================
   always_comb begin
      for (int k = 0; k < FETCH_WIDTH; k++) begin
         // Word index drops the two byte-offset bits
         taken_o[k] = ctr_q[lookup_pc_i[k][IDX_W+1:2]][1];   // Counter >= 2
      end
   end

   // ====================
   // Update
   // ====================
   always_comb begin
      for (int p = 0; p < RESOLVE_PORTS; p++) begin
         upd_idx[p] = resolve_i[p].pc[IDX_W+1:2];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         for (int i = 0; i < ENTRIES; i++) begin
            ctr_q[i] <= 2'd1;                            // Weakly not-taken
         end
      end else begin
         // Ascending port order, younger port wins on a shared entry
         for (int p = 0; p < RESOLVE_PORTS; p++) begin
            if (update_en_i[p]) begin
               ctr_q[upd_idx[p]] <= sat_next(ctr_q[upd_idx[p]], resolve_i[p].taken);
            end
         end
      end
   end

endmodule

//--- src/fetch_pkg.sv
package fetch_pkg;

   // ====================
   // Front end geometry
   // ====================
   localparam int FETCH_WIDTH   = 4;      // Slots per fetch group
   localparam int XLEN          = 32;     // Address and instruction width
   localparam int RESOLVE_PORTS = 2;      // In-order resolve ports from back end

   localparam logic [XLEN-1:0] RESET_PC = '0;   // First fetch address

   // Instruction classes seen by the early decoder
   typedef enum logic [1:0] {
      OP_BRANCH,    // Conditional branch, B-type
      OP_JAL,       // Direct jump, J-type
      OP_OTHER      // Anything else, falls through
   } opcode_e;

   // ====================
   // Grouped signals
   // ====================

   // One fetch slot
   typedef struct packed {
      logic [XLEN-1:0] pc;
      logic [XLEN-1:0] instr;
      logic            pred_taken;   // JAL or branch with taken counter
   } slot_t;

   // One fetch group, slot 0 at the lowest address
   typedef struct packed {
      slot_t [FETCH_WIDTH-1:0] slots;
      logic  [FETCH_WIDTH-1:0] valid;   // Slots up to first predicted-taken
   } fetch_group_t;

   // One resolve port
   typedef struct packed {
      logic            valid;
      logic            mispredict;   // Front end took the wrong path
      logic            is_branch;    // Conditional branch, trains predictor
      logic            taken;        // Actual direction
      logic [XLEN-1:0] pc;           // Branch pc, indexes the counter table
      logic [XLEN-1:0] correct_pc;   // Redirect target on mispredict
   } resolve_t;

   // Port 0 is the oldest
   typedef resolve_t [RESOLVE_PORTS-1:0] resolve_vec_t;

endpackage

//--- src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
   parameter int ENTRIES = 32                             // Predictor entries
)(
   input  logic                                                clk,
   input  logic                                                rst_n_i,
   output logic [fetch_pkg::XLEN-1:0]                          imem_addr_o,
   input  logic [fetch_pkg::FETCH_WIDTH-1:0][fetch_pkg::XLEN-1:0] imem_rdata_i,
   input  fetch_pkg::resolve_vec_t                             resolve_i,
   input  logic                                                ready_i,
   output logic                                                push_o,
   output fetch_pkg::fetch_group_t                             group_o,
   output logic                                                flush_o
);
   import fetch_pkg::*;

   logic [XLEN-1:0]                   fetch_pc;
   logic [FETCH_WIDTH-1:0][XLEN-1:0]  slot_pc;      // Per-slot pc, base plus 4k
   opcode_e                           op     [FETCH_WIDTH];
   logic [XLEN-1:0]                   offset [FETCH_WIDTH];
   logic [FETCH_WIDTH-1:0]            bp_taken;     // Counter says taken
   logic [FETCH_WIDTH-1:0]            pred;         // Slot redirects fetch
   logic [FETCH_WIDTH-1:0]            valid_mask;
   logic                              blocked;      // Earlier slot already taken
   logic                              redirect;
   logic [XLEN-1:0]                   redirect_pc;
   logic                              flush;
   logic [XLEN-1:0]                   flush_pc;
   logic                              older_mis;    // Mispredict seen on an older port
   logic [RESOLVE_PORTS-1:0]          update_en;
   logic                              fetch_en_q;   // Set once out of reset

   // ====================
   // Resolve handling
   // ====================
   always_comb begin
      flush     = 1'b0;
      flush_pc  = '0;
      older_mis = 1'b0;
      for (int p = 0; p < RESOLVE_PORTS; p++) begin
         update_en[p] = resolve_i[p].valid & resolve_i[p].is_branch & ~older_mis;
         if (resolve_i[p].valid && resolve_i[p].mispredict && !older_mis) begin
            flush    = 1'b1;
            flush_pc = resolve_i[p].correct_pc;   // Oldest mispredict only
         end
         older_mis = older_mis | (resolve_i[p].valid & resolve_i[p].mispredict);
      end
   end

   // ====================
   // Slot decode
   // ====================
   for (genvar k = 0; k < FETCH_WIDTH; k++) begin : g_slot
      assign slot_pc[k] = fetch_pc + XLEN'(4 * k);

      imm_decoder u_dec (
         .instr_i  (imem_rdata_i[k]),
         .op_o     (op[k]),
         .offset_o (offset[k])
      );

      // JAL always taken, branch follows its counter
      assign pred[k] = (op[k] == OP_JAL) | ((op[k] == OP_BRANCH) & bp_taken[k]);
   end

   branch_predictor #(.ENTRIES(ENTRIES)) u_bp (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .lookup_pc_i (slot_pc),
      .taken_o     (bp_taken),
      .update_en_i (update_en),
      .resolve_i   (resolve_i)
   );

   // First predicted-taken slot ends the group
   always_comb begin
      blocked     = 1'b0;
      redirect    = 1'b0;
      redirect_pc = '0;
      for (int k = 0; k < FETCH_WIDTH; k++) begin
         valid_mask[k] = ~blocked;
         if (!blocked && pred[k]) begin
            redirect    = 1'b1;
            redirect_pc = slot_pc[k] + offset[k];
            blocked     = 1'b1;                   // Later slots dropped
         end
      end
   end

   always_comb begin
      for (int k = 0; k < FETCH_WIDTH; k++) begin
         group_o.slots[k].pc         = slot_pc[k];
         group_o.slots[k].instr      = imem_rdata_i[k];
         group_o.slots[k].pred_taken = pred[k];
      end
      group_o.valid = valid_mask;
   end

   // ====================
   // Handshake and PC
   // ====================
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         fetch_en_q <= 1'b0;
      end else begin
         fetch_en_q <= 1'b1;
      end
   end

   assign push_o  = fetch_en_q & ready_i & ~flush;   // Never together with flush
   assign flush_o = flush;

   pc_gen u_pc (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .advance_i     (push_o),
      .flush_i       (flush),
      .flush_pc_i    (flush_pc),
      .redirect_i    (redirect),
      .redirect_pc_i (redirect_pc),
      .pc_o          (fetch_pc)
   );

   assign imem_addr_o = fetch_pc;

endmodule

//--- src/frontend_top.sv
`timescale 1ns/1ps

module frontend_top #(
   parameter int ENTRIES   = 32,    // Predictor entries
   parameter int BUF_DEPTH = 4      // Buffered groups
)(
   input  logic                                                clk,
   input  logic                                                rst_n_i,
   output logic [fetch_pkg::XLEN-1:0]                          imem_addr_o,
   input  logic [fetch_pkg::FETCH_WIDTH-1:0][fetch_pkg::XLEN-1:0] imem_rdata_i,
   input  fetch_pkg::resolve_vec_t                             resolve_i,
   output fetch_pkg::slot_t                                    out_slot_o,
   output logic                                                out_valid_o,
   input  logic                                                out_ready_i
);
   import fetch_pkg::*;

   fetch_group_t fetch_group;   // Fetch unit to buffer
   fetch_group_t head_group;    // Buffer to serializer
   logic         push;
   logic         buf_ready;
   logic         flush;
   logic         pop;
   logic         nonempty;

   // ====================
   // Producer
   // ====================
   fetch_unit #(.ENTRIES(ENTRIES)) u_fetch (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .imem_addr_o  (imem_addr_o),
      .imem_rdata_i (imem_rdata_i),
      .resolve_i    (resolve_i),
      .ready_i      (buf_ready),
      .push_o       (push),
      .group_o      (fetch_group),
      .flush_o      (flush)
   );

   inst_buffer #(.BUF_DEPTH(BUF_DEPTH)) u_buf (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .flush_i    (flush),
      .push_i     (push),
      .group_i    (fetch_group),
      .ready_o    (buf_ready),
      .pop_i      (pop),
      .head_o     (head_group),
      .nonempty_o (nonempty)
   );

   // Consumer, one instruction per handshake
   group_serializer u_ser (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .flush_i     (flush),
      .head_i      (head_group),
      .nonempty_i  (nonempty),
      .pop_o       (pop),
      .out_slot_o  (out_slot_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

endmodule

//--- src/group_serializer.sv
`timescale 1ns/1ps

module group_serializer (
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  logic                    flush_i,
   input  fetch_pkg::fetch_group_t head_i,
   input  logic                    nonempty_i,
   output logic                    pop_o,
   output fetch_pkg::slot_t        out_slot_o,
   output logic                    out_valid_o,
   input  logic                    out_ready_i
);
   import fetch_pkg::*;

   localparam int SEL_W = $clog2(FETCH_WIDTH);

   fetch_group_t           grp_q;      // Group being drained
   logic [FETCH_WIDTH-1:0] rem_q;      // Slots not yet handed out
   logic [FETCH_WIDTH-1:0] rem_next;
   logic [SEL_W-1:0]       sel;        // Lowest remaining slot
   logic                   fire;

   // Scan down so the lowest set bit wins
   always_comb begin
      sel = '0;
      for (int k = FETCH_WIDTH - 1; k >= 0; k--) begin
         if (rem_q[k]) begin
            sel = SEL_W'(k);
         end
      end
   end

   assign out_valid_o = |rem_q;
   assign out_slot_o  = grp_q.slots[sel];   // Stable until the handshake
   assign fire        = out_valid_o & out_ready_i;

   always_comb begin
      rem_next = rem_q;
      if (fire) begin
         rem_next[sel] = 1'b0;
      end
   end

   // Load when empty or as the last slot leaves
   assign pop_o = nonempty_i & ~flush_i & (rem_next == '0);

   // ====================
   // State
   // ====================
   always_ff @(posedge clk) begin
      if (!rst_n_i || flush_i) begin
         rem_q <= '0;
      end else if (pop_o) begin
         rem_q <= head_i.valid;
      end else begin
         rem_q <= rem_next;
      end
   end

   always_ff @(posedge clk) begin
      if (pop_o) begin
         grp_q <= head_i;                   // Payload only
      end
   end

endmodule

//--- src/imm_decoder.sv
`timescale 1ns/1ps

module imm_decoder (
   input  logic [fetch_pkg::XLEN-1:0] instr_i,
   output fetch_pkg::opcode_e         op_o,
   output logic [fetch_pkg::XLEN-1:0] offset_o
);
   import fetch_pkg::*;

   // Major opcodes, bits 6:0
   localparam logic [6:0] MAJOR_BRANCH = 7'b1100011;
   localparam logic [6:0] MAJOR_JAL    = 7'b1101111;

   always_comb begin
      case (instr_i[6:0])
         MAJOR_BRANCH: begin
            op_o = OP_BRANCH;
            // imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
            offset_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                        instr_i[30:25], instr_i[11:8], 1'b0};
         end
         MAJOR_JAL: begin
            op_o = OP_JAL;
            // imm[20|10:1|11|19:12] in 31:12
            offset_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                        instr_i[20], instr_i[30:21], 1'b0};
         end
         default: begin
            op_o     = OP_OTHER;
            offset_o = '0;               // No target for sequential code
         end
      endcase
   end

endmodule

//--- src/inst_buffer.sv
`timescale 1ns/1ps

module inst_buffer #(
   parameter int BUF_DEPTH = 4                  // Groups held
)(
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  logic                    flush_i,
   input  logic                    push_i,
   input  fetch_pkg::fetch_group_t group_i,
   output logic                    ready_o,     // Room for one group
   input  logic                    pop_i,
   output fetch_pkg::fetch_group_t head_o,
   output logic                    nonempty_o
);
   import fetch_pkg::*;

   localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
   localparam int CNT_W = PTR_W + 1;
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(BUF_DEPTH - 1);
   localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(BUF_DEPTH);

   fetch_group_t     mem [BUF_DEPTH];    // Group storage
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             do_push;
   logic             do_pop;

   // Wrap for any depth, not only powers of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
   endfunction

   assign nonempty_o = (count_q != '0);
   assign ready_o    = (count_q != FULL_CNT) | pop_i;   // Full but draining is fine
   assign do_push    = push_i & ready_o;
   assign do_pop     = pop_i & nonempty_o;
   assign head_o     = mem[rd_ptr_q];

   // ====================
   // Pointers and count
   // ====================
   always_ff @(posedge clk) begin
      if (!rst_n_i || flush_i) begin
         wr_ptr_q <= '0;                 // Flush drops every stored group
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= ptr_inc(wr_ptr_q);
         end
         if (do_pop) begin
            rd_ptr_q <= ptr_inc(rd_ptr_q);
         end
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;  // Both or neither
         endcase
      end
   end

   // Storage
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr_q] <= group_i;
      end
   end

endmodule

//--- src/pc_gen.sv
`timescale 1ns/1ps

module pc_gen (
   input  logic                       clk,
   input  logic                       rst_n_i,
   input  logic                       advance_i,      // Group accepted this cycle
   input  logic                       flush_i,        // Back end mispredict
   input  logic [fetch_pkg::XLEN-1:0] flush_pc_i,
   input  logic                       redirect_i,     // Predicted-taken slot in group
   input  logic [fetch_pkg::XLEN-1:0] redirect_pc_i,
   output logic [fetch_pkg::XLEN-1:0] pc_o
);
   import fetch_pkg::*;

   // One group is FETCH_WIDTH words
   localparam logic [XLEN-1:0] GROUP_BYTES = XLEN'(FETCH_WIDTH * 4);

   logic [XLEN-1:0] pc_q;
   logic [XLEN-1:0] pc_seq;

   assign pc_seq = pc_q + GROUP_BYTES;   // Fall-through address

   // Flush over prediction over sequential
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         pc_q <= RESET_PC;
      end else if (flush_i) begin
         pc_q <= flush_pc_i;                 // Back end always wins
      end else if (advance_i) begin
         if (redirect_i) begin
            pc_q <= redirect_pc_i;           // Follow predicted target
         end else begin
            pc_q <= pc_seq;
         end
      end
      // No push and no flush, hold
   end

   assign pc_o = pc_q;

endmodule
